//--- src/game_pkg.sv
`default_nettype none

package game_pkg;

    localparam int COORD_W = 10;
    localparam int STAGE_W = 4;

    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [STAGE_W-1:0] stage_t;

    typedef struct packed {
        coord_t h;
        coord_t v;
    } pos_t;

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } keys_t;

    typedef struct packed {
        logic blk_right_move;
        logic blk_left_move;
        logic blk_up_move;
        logic blk_down_move;
    } blocked_t;

    localparam stage_t LAST_STAGE = 4'd10;

    localparam coord_t WALL_SIZE = 10'd20;  // tile size, also contact distance
    localparam coord_t EDGE_LO   = 10'd20;
    localparam coord_t EDGE_HI   = 10'd319;

    localparam pos_t PLAYER_START_0 = '{h: 10'd150, v: 10'd110};
    localparam pos_t PLAYER_START_N = '{h: 10'd25,  v: 10'd25};
    localparam pos_t MONSTER_START  = '{h: 10'd160, v: 10'd120};

    localparam logic [12:0] LFSR_SEED = 13'h000F;  // must not be all zero

    localparam int NUM_WALLS = 40;

    // reference corner of each wall tile, (h, v)
    localparam pos_t WALL_POS [NUM_WALLS] = '{
        '{10'd320, 10'd120}, '{10'd300, 10'd120}, '{10'd280, 10'd120}, '{10'd260, 10'd160},
        '{10'd240, 10'd180}, '{10'd220, 10'd160}, '{10'd200, 10'd180}, '{10'd180, 10'd180},
        '{10'd160, 10'd180}, '{10'd140, 10'd180}, '{10'd120, 10'd180}, '{10'd100, 10'd140},
        '{10'd80,  10'd140}, '{10'd60,  10'd140}, '{10'd40,  10'd140}, '{10'd20,  10'd140},
        '{10'd320, 10'd60},  '{10'd300, 10'd60},  '{10'd280, 10'd60},  '{10'd260, 10'd60},
        '{10'd240, 10'd60},  '{10'd220, 10'd60},  '{10'd200, 10'd60},  '{10'd180, 10'd60},
        '{10'd160, 10'd60},  '{10'd140, 10'd60},  '{10'd120, 10'd60},  '{10'd100, 10'd60},
        '{10'd80,  10'd60},  '{10'd60,  10'd60},  '{10'd40,  10'd60},  '{10'd20,  10'd60},
        '{10'd280, 10'd140}, '{10'd100, 10'd160}, '{10'd320, 10'd140}, '{10'd300, 10'd140},
        '{10'd80,  10'd160}, '{10'd60,  10'd160}, '{10'd40,  10'd160}, '{10'd20,  10'd160}
    };

endpackage

`default_nettype wire

//--- src/lfsr13.sv
`default_nettype none

module lfsr13
    import game_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    output logic [12:0] rnd
);

    logic feedback;

    assign feedback = rnd[12] ^ rnd[3] ^ rnd[2] ^ rnd[0];  // taps 13,4,3,1

    always_ff @(posedge clk) begin
        if (rst) begin
            rnd <= LFSR_SEED;
        end else begin
            rnd <= {rnd[11:0], feedback};
        end
    end

endmodule

`default_nettype wire

//--- src/wall_collide.sv
`default_nettype none

module wall_collide
    import game_pkg::*;
(
    input  pos_t     player_pos,
    output blocked_t blocked
);

    blocked_t hit [NUM_WALLS];

    // contact test of the player against one wall tile
    function automatic blocked_t wall_hit(pos_t p, pos_t w);
        coord_t   dv;
        coord_t   dh;
        blocked_t b;
        dv = (p.v > w.v) ? p.v - w.v : w.v - p.v;
        dh = (p.h > w.h) ? p.h - w.h : w.h - p.h;
        b  = '0;
        if (dv < WALL_SIZE) begin  // side by side
            b.blk_right_move = (p.h == w.h + WALL_SIZE);
            b.blk_left_move  = (p.h + WALL_SIZE == w.h);
        end else if (dh < WALL_SIZE) begin  // stacked
            b.blk_up_move    = (p.v + WALL_SIZE == w.v);
            b.blk_down_move  = (p.v == w.v + WALL_SIZE);
        end
        return b;
    endfunction

    for (genvar i = 0; i < NUM_WALLS; i++) begin : g_wall
        assign hit[i] = wall_hit(player_pos, WALL_POS[i]);
    end

    always_comb begin
        blocked = '0;
        for (int i = 0; i < NUM_WALLS; i++) begin
            blocked = blocked | hit[i];
        end
    end

endmodule

`default_nettype wire

//--- src/player_move.sv
`default_nettype none

module player_move
    import game_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     reload,
    input  stage_t   next_stage,
    input  keys_t    keys,
    input  blocked_t blocked,
    output pos_t     pos,
    output logic     go_back,
    output logic     go_next
);

    pos_t pos_nxt;

    // up > down > left > right, one pixel per clock
    always_comb begin
        pos_nxt = pos;
        if (keys.up) begin
            if (!blocked.blk_up_move) begin
                pos_nxt.v = pos.v + 1'b1;
            end
        end else if (keys.down) begin
            if (!blocked.blk_down_move) begin
                pos_nxt.v = pos.v - 1'b1;
            end
        end else if (keys.left) begin
            if (!blocked.blk_left_move) begin
                pos_nxt.h = pos.h + 1'b1;  // screen h runs mirrored
            end
        end else if (keys.right) begin
            if (!blocked.blk_right_move) begin
                pos_nxt.h = pos.h - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || (reload && next_stage == '0)) begin
            pos <= PLAYER_START_0;
        end else if (reload) begin
            pos <= PLAYER_START_N;
        end else begin
            pos <= pos_nxt;
        end
    end

    // edge flags, one clock behind the position
    // cleared on reload so a single crossing gives a single step
    always_ff @(posedge clk) begin
        if (rst || reload) begin
            go_back <= 1'b0;
            go_next <= 1'b0;
        end else begin
            go_back <= (pos.h >= EDGE_HI);
            go_next <= (pos.h <= EDGE_LO);
        end
    end

endmodule

`default_nettype wire

//--- src/stage_ctrl.sv
`default_nettype none

module stage_ctrl
    import game_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   go_back,
    input  logic   go_next,
    output stage_t stage,
    output stage_t next_stage,
    output logic   stage_change
);

    always_comb begin
        next_stage = stage;
        if (go_next) begin  // forward wins
            if (stage != LAST_STAGE) begin
                next_stage = stage + 1'b1;
            end
        end else if (go_back) begin
            if (stage != '0) begin
                next_stage = stage - 1'b1;
            end
        end
    end

    assign stage_change = go_next | go_back;  // also at the saturated ends

    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= '0;
        end else begin
            stage <= next_stage;
        end
    end

endmodule

`default_nettype wire

//--- src/monster_walk.sv
`default_nettype none

module monster_walk
    import game_pkg::*;
#(
    parameter int STEP_PERIOD = 3
) (
    input  logic clk,
    input  logic rst,
    input  logic reload,
    output pos_t pos
);

    localparam int CNT_W = $clog2(STEP_PERIOD);

    logic [CNT_W-1:0] step_cnt;
    logic [12:0]      rnd;
    logic             step;
    coord_t           delta;

    lfsr13 u_lfsr (
        .clk (clk),
        .rst (rst | reload),
        .rnd (rnd)
    );

    assign step  = (step_cnt == CNT_W'(STEP_PERIOD - 1));
    assign delta = coord_t'(rnd % 13'd3) - 10'd1;  // -1, 0 or +1

    always_ff @(posedge clk) begin
        if (rst || reload) begin
            step_cnt <= '0;
            pos      <= MONSTER_START;
        end else if (step) begin
            step_cnt <= '0;
            if (!rnd[0]) begin  // even value moves h
                pos.h <= pos.h + delta;
            end else begin
                pos.v <= pos.v + delta;
            end
        end else begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/game_top.sv
`default_nettype none

module game_top
    import game_pkg::*;
#(
    parameter int STEP_PERIOD = 3
) (
    input  logic   clk,
    input  logic   rst,
    input  keys_t  keys,
    output pos_t   player_pos,
    output pos_t   monster_pos,
    output stage_t stage
);

    blocked_t blocked;
    stage_t   next_stage;
    logic     go_back;
    logic     go_next;
    logic     stage_change;
    logic     reload;

    assign reload = rst | stage_change;  // movers restart on every stage step

    stage_ctrl u_stage (
        .clk          (clk),
        .rst          (rst),
        .go_back      (go_back),
        .go_next      (go_next),
        .stage        (stage),
        .next_stage   (next_stage),
        .stage_change (stage_change)
    );

    player_move u_player (
        .clk        (clk),
        .rst        (rst),
        .reload     (reload),
        .next_stage (next_stage),
        .keys       (keys),
        .blocked    (blocked),
        .pos        (player_pos),
        .go_back    (go_back),
        .go_next    (go_next)
    );

    wall_collide u_walls (
        .player_pos (player_pos),
        .blocked    (blocked)
    );

    monster_walk #(
        .STEP_PERIOD (STEP_PERIOD)
    ) u_monster (
        .clk    (clk),
        .rst    (rst),
        .reload (reload),
        .pos    (monster_pos)
    );

endmodule

`default_nettype wire

//--- tb/clock_gen.sv
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD = 50;  // 100 ns clock
    localparam int RST_CYCLES  = 8;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- tb/game_checker.sv
`default_nettype none

module game_checker
    import game_pkg::*;
#(
    parameter int STEP_PERIOD = 3
) (
    input  logic   clk,
    input  logic   rst,
    input  keys_t  keys,
    input  pos_t   player_pos,
    input  pos_t   monster_pos,
    input  stage_t stage,
    input  logic   done,
    output int     err_player,
    output int     err_monster,
    output int     err_stage,
    output int     err_cover
);
    timeunit 1ns;
    timeprecision 100ps;

    pos_t        m_player;
    pos_t        m_mon;
    stage_t      m_stage;
    logic        m_back;
    logic        m_next;
    int          m_cnt;
    logic [12:0] m_lfsr;
    logic        m_valid;
    int          steps;
    int          stopped;
    logic        saw_last;
    string       player_test;
    string       monster_test;
    string       stage_test;

    initial begin
        err_player  = 0;
        err_monster = 0;
        err_stage   = 0;
        err_cover   = 0;
        m_valid     = 1'b0;
        steps       = 0;
        stopped     = 0;
        saw_last    = 1'b0;
    end

    // blocked directions of the player against all walls, 10-bit screen wrap
    function automatic blocked_t model_blocked(input pos_t p);
        blocked_t b;
        int       ph;
        int       pv;
        int       wh;
        int       wv;
        int       dh;
        int       dv;
        int       sz;
        b  = '0;
        ph = int'(p.h);
        pv = int'(p.v);
        sz = int'(WALL_SIZE);
        for (int i = 0; i < NUM_WALLS; i++) begin
            wh = int'(WALL_POS[i].h);
            wv = int'(WALL_POS[i].v);
            dh = (ph > wh) ? ph - wh : wh - ph;
            dv = (pv > wv) ? pv - wv : wv - pv;
            if (dv < sz) begin
                if (ph == (wh + sz) % 1024) b.blk_right_move = 1'b1;
                if ((ph + sz) % 1024 == wh) b.blk_left_move = 1'b1;
            end else if (dh < sz) begin
                if ((pv + sz) % 1024 == wv) b.blk_up_move = 1'b1;
                if (pv == (wv + sz) % 1024) b.blk_down_move = 1'b1;
            end
        end
        return b;
    endfunction

    function automatic pos_t apply_keys(input pos_t p, input keys_t k, input blocked_t b,
                                        output logic stop);
        pos_t q;
        q    = p;
        stop = 1'b0;
        if (k.up) begin
            stop = b.blk_up_move;
            if (!stop) q.v = p.v + 10'd1;
        end else if (k.down) begin
            stop = b.blk_down_move;
            if (!stop) q.v = p.v - 10'd1;
        end else if (k.left) begin
            stop = b.blk_left_move;
            if (!stop) q.h = p.h + 10'd1;
        end else if (k.right) begin
            stop = b.blk_right_move;
            if (!stop) q.h = p.h - 10'd1;
        end
        return q;
    endfunction

    function automatic pos_t monster_step(input pos_t p, input logic [12:0] r);
        pos_t q;
        int   d;
        q = p;
        d = int'(r % 13'd3) - 1;
        if (r[0] == 1'b0) begin
            q.h = coord_t'(int'(p.h) + d);
        end else begin
            q.v = coord_t'(int'(p.v) + d);
        end
        return q;
    endfunction

    always @(posedge clk) begin
        blocked_t b;
        stage_t   ns;
        logic     chg;
        logic     stop;
        logic     nb;
        logic     nn;
        if (rst) begin
            m_player     = PLAYER_START_0;
            m_mon        = MONSTER_START;
            m_stage      = '0;
            m_back       = 1'b0;
            m_next       = 1'b0;
            m_cnt        = 0;
            m_lfsr       = LFSR_SEED;
            m_valid      = 1'b1;
            player_test  = "reset_state";
            monster_test = "reset_state";
            stage_test   = "reset_state";
        end else begin
            chg = m_next | m_back;
            ns  = m_stage;
            if (m_next) begin
                if (m_stage != LAST_STAGE) ns = m_stage + 4'd1;
            end else if (m_back) begin
                if (m_stage != '0) ns = m_stage - 4'd1;
            end
            nb = (m_player.h >= EDGE_HI);  // flags from the old position
            nn = (m_player.h <= EDGE_LO);
            stage_test = "stage_step";
            if (chg) begin
                m_player     = (ns == '0) ? PLAYER_START_0 : PLAYER_START_N;
                m_back       = 1'b0;
                m_next       = 1'b0;
                m_mon        = MONSTER_START;
                m_cnt        = 0;
                m_lfsr       = LFSR_SEED;
                steps++;
                player_test  = "stage_step";
                monster_test = "stage_step";
            end else begin
                b            = model_blocked(m_player);
                m_player     = apply_keys(m_player, keys, b, stop);
                m_back       = nb;
                m_next       = nn;
                player_test  = stop ? "wall_block" : "player_move";
                monster_test = "monster_walk";
                if (stop) stopped++;
                if (m_cnt == STEP_PERIOD - 1) begin
                    m_cnt = 0;
                    m_mon = monster_step(m_mon, m_lfsr);
                end else begin
                    m_cnt++;
                end
                m_lfsr = {m_lfsr[11:0], m_lfsr[12] ^ m_lfsr[3] ^ m_lfsr[2] ^ m_lfsr[0]};
            end
            m_stage = ns;
            if (m_stage == LAST_STAGE) saw_last = 1'b1;
        end
    end

    // outputs settled since the rising edge
    always @(negedge clk) begin
        if (m_valid) begin
            if (player_pos !== m_player) begin
                $display("error %s expected (%0d,%0d) actual (%0d,%0d)", player_test,
                         m_player.h, m_player.v, player_pos.h, player_pos.v);
                err_player++;
            end
            if (monster_pos !== m_mon) begin
                $display("error %s expected (%0d,%0d) actual (%0d,%0d)", monster_test,
                         m_mon.h, m_mon.v, monster_pos.h, monster_pos.v);
                err_monster++;
            end
            if (stage !== m_stage) begin
                $display("error %s expected %0d actual %0d", stage_test, m_stage, stage);
                err_stage++;
            end
        end
    end

    always @(posedge done) begin
        if (!saw_last) begin
            $display("the stage never reached %0d during the run (%0d steps)",
                     LAST_STAGE, steps);
            err_cover++;
        end
        if (stopped == 0) begin
            $display("no key press was ever stopped by a wall");
            err_cover++;
        end
    end

endmodule

`default_nettype wire

//--- tb/game_tb.sv
`default_nettype none

module game_tb
    import game_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int STEP_PERIOD   = 3;
    localparam int RUN_CYCLES    = 6000;
    localparam int CLK_PERIOD_NS = 100;
    localparam int TIMEOUT_NS    = (RUN_CYCLES + 100) * CLK_PERIOD_NS;

    localparam keys_t KEY_NONE  = '{up: 1'b0, down: 1'b0, left: 1'b0, right: 1'b0};
    localparam keys_t KEY_RIGHT = '{up: 1'b0, down: 1'b0, left: 1'b0, right: 1'b1};
    localparam keys_t KEY_LEFT  = '{up: 1'b0, down: 1'b0, left: 1'b1, right: 1'b0};
    localparam keys_t KEY_DOWN  = '{up: 1'b0, down: 1'b1, left: 1'b0, right: 1'b0};

    logic        clk;
    logic        rst;
    keys_t       keys;
    pos_t        player_pos;
    pos_t        monster_pos;
    stage_t      stage;
    logic        done;
    int          err_player;
    int          err_monster;
    int          err_stage;
    int          err_cover;
    int          cycles;
    logic [31:0] rng;

    clock_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    game_top #(
        .STEP_PERIOD (STEP_PERIOD)
    ) dut (
        .clk         (clk),
        .rst         (rst),
        .keys        (keys),
        .player_pos  (player_pos),
        .monster_pos (monster_pos),
        .stage       (stage)
    );

    game_checker #(
        .STEP_PERIOD (STEP_PERIOD)
    ) u_check (
        .clk         (clk),
        .rst         (rst),
        .keys        (keys),
        .player_pos  (player_pos),
        .monster_pos (monster_pos),
        .stage       (stage),
        .done        (done),
        .err_player  (err_player),
        .err_monster (err_monster),
        .err_stage   (err_stage),
        .err_cover   (err_cover)
    );

    // fibonacci lfsr with taps 32,22,2,1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb  = rng[31] ^ rng[21] ^ rng[1] ^ rng[0];
            rng = {rng[30:0], fb};
            v   = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic hold_keys(input keys_t k, input int n);
        keys = k;
        repeat (n) @(negedge clk);
        cycles += n;
    endtask

    initial begin
        int          kind;
        int          hold;
        logic [31:0] bits;
        keys_t       pat;
        keys   = KEY_NONE;
        done   = 1'b0;
        cycles = 0;
        rng    = 32'hd58f;
        @(negedge rst);
        hold_keys(KEY_DOWN, 20);  // off the wall row at v=120
        hold_keys(KEY_LEFT, 200);  // back step on stage 0
        hold_keys(KEY_RIGHT, 163);  // forward step to stage 1
        hold_keys(KEY_LEFT, 300);  // back step from stage 1 to stage 0
        while (cycles < RUN_CYCLES) begin
            kind = int'(take_bits(3));
            hold = int'(take_bits(6)) + 1;
            if (cycles + hold > RUN_CYCLES) begin
                hold = RUN_CYCLES - cycles;
            end
            if (kind < 4) begin
                pat = KEY_RIGHT;  // drift toward the left edge
            end else if (kind == 4) begin
                pat = KEY_LEFT;
            end else begin
                bits = take_bits(4);
                pat  = bits[3:0];
            end
            hold_keys(pat, hold);
        end
        keys = KEY_NONE;
        done = 1'b1;
        repeat (2) @(negedge clk);
        $display("error counts: player %0d, monster %0d, stage %0d, coverage %0d",
                 err_player, err_monster, err_stage, err_cover);
        if (err_player + err_monster + err_stage + err_cover == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: the run did not end within %0d ns", TIMEOUT_NS);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
src/game_pkg.sv
src/lfsr13.sv
src/wall_collide.sv
src/player_move.sv
src/stage_ctrl.sv
src/monster_walk.sv
src/game_top.sv
tb/clock_gen.sv
tb/game_checker.sv
tb/game_tb.sv

//--- Makefile
# build and run the game testbench with Verilator

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
		-f sim.f --top-module game_tb --Mdir obj_dir -o game_sim
	./obj_dir/game_sim | tee sim.log
	grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
